/* Bender.yml */
package:
  name: excp_unit

sources:
  - files:
      - logic/excp_pkg.sv
      - logic/ctrl_csr_if.sv
      - logic/csr_file.sv
      - logic/ctrl.sv
      - logic/excp_unit.sv
  - target: test
    files:
      - bench/tb_excp_unit.sv

/* bench/excp_testdata.txt */
# num mode valid cause pc badv ertn idle cont preq hw we waddr wdata raddr (hex except num, mode)
# then expected rdata flush new_pc int pause send; mode 1 checks after one quiet cycle
01 0 00 00000000 00000000 00000000 0 0 0 00 00 0 000 00000000 000 00000000 0 00000000 0 00 1
02 1 00 00000000 00000000 00000000 0 0 0 00 00 1 00c 1c0008ff 00c 1c0008c0 0 1c0008c0 0 00 1
03 1 00 00000000 00000000 00000000 0 0 0 00 00 1 004 0000ffff 004 00001bff 0 1c0008c0 0 00 1
04 0 16 2087ad4c 1c000100 deadbeef 0 0 0 00 00 0 000 00000000 005 00000000 1 1c0008c0 0 00 1
05 0 00 00000000 1c000100 deadbeef 0 0 0 00 00 0 000 00000000 005 00480000 0 1c0008c0 0 00 1
06 0 00 00000000 1c000100 deadbeef 0 0 0 00 00 0 000 00000000 006 1c000100 0 1c0008c0 0 00 1
07 0 00 00000000 1c000100 deadbeef 0 0 0 00 00 0 000 00000000 007 deadbeef 0 1c0008c0 0 00 1
08 0 21 20000002 1c000200 00001234 0 0 0 00 00 0 000 00000000 000 00000000 1 1c0008c0 0 00 1
09 0 00 00000000 1c000200 00001234 0 0 0 00 00 0 000 00000000 005 003f0000 0 1c0008c0 0 00 1
10 0 01 0000000f 1c000300 00000000 0 0 0 00 00 0 000 00000000 006 1c000200 1 1c0008c0 0 00 1
11 0 00 00000000 1c000300 00000000 0 0 0 00 00 0 000 00000000 005 00120000 0 1c0008c0 0 00 1
12 0 00 00000000 1c000300 00000000 1 0 0 00 00 0 000 00000000 000 00000000 1 1c000300 0 00 1
13 0 00 00000000 1c000300 00000000 1 0 0 00 00 1 006 1c000880 006 1c000300 1 1c000880 0 00 1
14 0 01 0000000a 1c000500 00000000 0 0 0 00 00 1 00c 1c001000 00c 1c0008c0 1 1c001000 0 00 1
15 0 00 00000000 1c000500 00000000 0 0 0 00 00 0 000 00000000 00c 1c001000 0 1c001000 0 00 1
16 0 01 0000000b 1c000600 00000000 0 0 0 00 00 1 006 12345678 006 1c000500 1 1c001000 0 00 1
17 0 00 00000000 1c000600 00000000 0 0 0 00 00 0 000 00000000 006 1c000600 0 1c001000 0 00 1
18 0 00 00000000 1c000600 00000000 0 0 0 00 00 1 005 00000001 000 00000000 0 1c001000 0 00 1
19 0 00 00000000 1c000600 00000000 0 0 0 00 00 1 000 00000004 005 000c0001 0 1c001000 1 00 1
20 1 00 00000000 1c000600 00000000 0 0 0 00 00 1 005 00000000 005 000c0000 0 1c001000 0 00 1
21 1 00 00000000 1c000600 00000000 0 0 0 00 04 0 000 00000000 005 000c0010 0 1c001000 1 00 1
22 1 00 00000000 1c000600 00000000 0 0 0 00 04 1 004 00000003 004 00000003 0 1c001000 0 00 1
23 0 00 00000000 1c000600 00000000 0 0 0 00 04 1 005 00000002 000 00000004 0 1c001000 1 00 1
24 0 01 00000009 1c000700 00000000 0 0 0 00 04 0 000 00000000 000 00000004 1 1c001000 1 00 1
25 0 00 00000000 1c000700 00000000 0 0 0 00 04 0 000 00000000 000 00000008 0 1c001000 0 00 1
26 0 00 00000000 1c000700 00000000 1 0 0 00 04 0 000 00000000 000 00000008 1 1c000700 0 00 1
27 0 00 00000000 1c000700 00000000 0 0 0 00 04 0 000 00000000 000 0000000c 0 1c001000 1 00 1
28 0 00 00000000 1c000700 00000000 0 0 0 01 04 0 000 00000000 000 0000000c 0 1c001000 1 01 1
29 0 00 00000000 1c000700 00000000 0 0 0 02 04 0 000 00000000 000 0000000c 0 1c001000 1 0f 0
30 0 00 00000000 1c000700 00000000 0 0 0 04 04 0 000 00000000 000 0000000c 0 1c001000 1 1f 0
31 0 00 00000000 1c000700 00000000 0 0 0 08 04 0 000 00000000 000 0000000c 0 1c001000 1 3f 0
32 0 00 00000000 1c000700 00000000 0 0 0 10 04 0 000 00000000 000 0000000c 0 1c001000 1 7f 0
33 0 00 00000000 1c000700 00000000 0 0 0 1c 04 0 000 00000000 000 0000000c 0 1c001000 1 1f 0
34 0 00 00000000 1c000700 00000000 0 0 0 1f 04 0 000 00000000 000 0000000c 0 1c001000 1 01 1
35 0 00 00000000 1c000700 00000000 0 1 0 00 04 0 000 00000000 000 0000000c 0 1c001000 1 00 1
36 1 00 00000000 1c000700 00000000 0 0 0 00 04 1 000 00000000 000 00000000 0 1c001000 0 00 1
37 0 00 00000000 1c000700 00000000 0 1 0 00 04 0 000 00000000 000 00000000 0 1c001000 0 7f 0
38 0 00 00000000 1c000700 00000000 0 1 1 00 04 0 000 00000000 000 00000000 0 1c001000 0 00 1
39 0 00 00000000 1c000700 00000000 0 1 0 00 04 1 000 00000004 000 00000000 0 1c001000 1 00 1
40 0 00 00000000 1c000700 00000000 0 1 0 02 04 0 000 00000000 000 00000004 0 1c001000 1 0f 0
41 0 00 00000000 1c000700 00000000 0 0 0 00 04 0 000 00000000 005 00090012 0 1c001000 1 00 1

/* bench/tb_excp_unit.sv */
`timescale 1ns/1ns

module tb_excp_unit;

    localparam string VEC_FILE  = "bench/excp_testdata.txt";
    localparam int    RESET_CYC = 10;

    logic        clk_i;
    logic        rst_n_i;
    logic [31:0] mem_pc_i;
    logic [31:0] mem_badv_i;
    logic [5:0]  mem_exc_valid_i;
    logic [29:0] mem_exc_cause_i;
    logic        mem_is_ertn_i;
    logic        mem_is_idle_i;
    logic        continue_idle_i;
    logic [4:0]  pause_req_i;
    logic [7:0]  hw_int_i;
    logic        wb_csr_we_i;
    logic [13:0] wb_csr_addr_i;
    logic [31:0] wb_csr_wdata_i;
    logic [13:0] csr_raddr_i;
    logic [31:0] csr_rdata_o;
    logic        exception_flush_o;
    logic [31:0] exception_new_pc_o;
    logic        is_interrupt_o;
    logic [6:0]  pause_o;
    logic        send_inst1_en_o;

    // Fields of the current vector line
    int          v_num, v_mode;
    logic [31:0] v_valid, v_cause, v_pc, v_badv, v_ertn, v_idle, v_cont;
    logic [31:0] v_preq, v_hw, v_we, v_waddr, v_wdata, v_raddr;
    logic [31:0] e_rdata, e_flush, e_npc, e_int, e_pause, e_send;

    string lines[$];
    int    errors = 0;
    int    passed = 0;
    int    failed = 0;
    int    cycles = 0;
    int    limit  = 0;

    excp_unit #(.ENTRY_ALIGN(6)) u_excp_unit (.*);

    always #10 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("simulation timed out after %0d cycles", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // **************************************************
    // Helpers
    // **************************************************

    task automatic compare(input string name, input logic [31:0] expv, input logic [31:0] actv);
        if (actv !== expv) begin
            $display("Fail at %0t ns: %s expected %h actual %h", $time, name, expv, actv);
            errors++;
        end
    endtask

    // One-cycle strobes back to idle, PC, BADV, IRQ lines and read address held
    task automatic clear_strobes();
        mem_exc_valid_i <= '0;
        mem_exc_cause_i <= '0;
        mem_is_ertn_i   <= 1'b0;
        mem_is_idle_i   <= 1'b0;
        continue_idle_i <= 1'b0;
        pause_req_i     <= '0;
        wb_csr_we_i     <= 1'b0;
        wb_csr_addr_i   <= '0;
        wb_csr_wdata_i  <= '0;
    endtask

    task automatic run_vector(input string text);
        int n;
        int errs_before;
        errs_before = errors;
        n = $sscanf(text, "%d %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    v_num, v_mode, v_valid, v_cause, v_pc, v_badv, v_ertn, v_idle, v_cont,
                    v_preq, v_hw, v_we, v_waddr, v_wdata, v_raddr,
                    e_rdata, e_flush, e_npc, e_int, e_pause, e_send);
        if (n != 21) begin
            $display("malformed vector line: %s", text);
            errors++;
            failed++;
        end else begin
            @(posedge clk_i);
            mem_exc_valid_i <= v_valid[5:0];
            mem_exc_cause_i <= v_cause[29:0];
            mem_pc_i        <= v_pc;
            mem_badv_i      <= v_badv;
            mem_is_ertn_i   <= v_ertn[0];
            mem_is_idle_i   <= v_idle[0];
            continue_idle_i <= v_cont[0];
            pause_req_i     <= v_preq[4:0];
            hw_int_i        <= v_hw[7:0];
            wb_csr_we_i     <= v_we[0];
            wb_csr_addr_i   <= v_waddr[13:0];
            wb_csr_wdata_i  <= v_wdata;
            csr_raddr_i     <= v_raddr[13:0];
            if (v_mode != 0) begin
                @(posedge clk_i);
                clear_strobes();
            end
            @(negedge clk_i);   // Outputs settled mid-cycle
            compare("csr_rdata_o", e_rdata, csr_rdata_o);
            compare("exception_flush_o", e_flush, exception_flush_o);
            compare("exception_new_pc_o", e_npc, exception_new_pc_o);
            compare("is_interrupt_o", e_int, is_interrupt_o);
            compare("pause_o", e_pause, pause_o);
            compare("send_inst1_en_o", e_send, send_inst1_en_o);
            if (errors == errs_before) begin
                $display("test %0d passed", v_num);
                passed++;
            end else begin
                $display("test %0d failed", v_num);
                failed++;
            end
        end
    endtask

    // **************************************************
    // Main sequence
    // **************************************************

    initial begin
        int    fd;
        string text;
        clk_i           = 1'b0;
        rst_n_i         = 1'b0;
        mem_pc_i        = '0;
        mem_badv_i      = '0;
        hw_int_i        = '0;
        csr_raddr_i     = '0;
        mem_exc_valid_i = '0;
        mem_exc_cause_i = '0;
        mem_is_ertn_i   = 1'b0;
        mem_is_idle_i   = 1'b0;
        continue_idle_i = 1'b0;
        pause_req_i     = '0;
        wb_csr_we_i     = 1'b0;
        wb_csr_addr_i   = '0;
        wb_csr_wdata_i  = '0;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("cannot open vector file %s", VEC_FILE);
            errors++;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(text, fd) > 0 && text.len() > 1 && text.substr(0, 0) != "#") begin
                    lines.push_back(text);
                end
            end
            $fclose(fd);
        end
        if (lines.size() == 0) begin
            $display("no test vectors were read");
            errors++;
        end
        limit = lines.size() * 4 + RESET_CYC;
        repeat (RESET_CYC) @(posedge clk_i);
        rst_n_i <= 1'b1;
        foreach (lines[k]) begin
            run_vector(lines[k]);
        end
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 lines.size(), passed, failed, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* flist.f */
logic/excp_pkg.sv
logic/ctrl_csr_if.sv
logic/csr_file.sv
logic/ctrl.sv
logic/excp_unit.sv
bench/tb_excp_unit.sv

/* logic/csr_file.sv */
`timescale 1ns/1ns

module csr_file #(
    parameter int ENTRY_ALIGN = 6
) (
    input  logic                               clk_i,
    input  logic                               rst_n_i,
    input  logic [excp_pkg::HW_INT_BITS-1:0]   hw_int_i,
    input  logic                               wb_csr_we_i,
    input  logic [excp_pkg::CSR_ADDR_W-1:0]    wb_csr_addr_i,
    input  logic [31:0]                        wb_csr_wdata_i,
    input  logic [excp_pkg::CSR_ADDR_W-1:0]    csr_raddr_i,
    output logic [31:0]                        csr_rdata_o,
    ctrl_csr_if.csr                            bus
);
    import excp_pkg::*;

    localparam logic [31:0] EENTRY_MASK = ~((32'd1 << ENTRY_ALIGN) - 32'd1);

    logic                   crmd_ie_q;
    logic                   crmd_pie_q;
    logic [INT_BITS-1:0]    ecfg_lie_q;
    logic [1:0]             estat_sw_q;
    logic [HW_INT_BITS-1:0] estat_hw_q;
    logic [ECODE_W-1:0]     ecode_q;
    logic [ESUBCODE_W-1:0]  esubcode_q;
    logic [31:0]            era_q;
    logic [31:0]            badv_q;
    logic [31:0]            eentry_q;
    logic [INT_BITS-1:0]    estat_is;
    estat_word_u            wb_word;
    estat_word_u            estat_rd;

    assign wb_word.raw = wb_csr_wdata_i;
    assign estat_is    = {2'b00, estat_hw_q, estat_sw_q};  // No timer or IPI source

    // **************************************************
    // Register update
    // **************************************************

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            crmd_ie_q  <= 1'b0;
            crmd_pie_q <= 1'b0;
            ecfg_lie_q <= '0;
            estat_sw_q <= '0;
            estat_hw_q <= '0;
            ecode_q    <= '0;
            esubcode_q <= '0;
            era_q      <= '0;
            badv_q     <= '0;
            eentry_q   <= '0;
        end else begin
            estat_hw_q <= hw_int_i;     // Sampled every cycle
            if (wb_csr_we_i) begin
                case (wb_csr_addr_i)
                    CSR_CRMD: begin
                        crmd_ie_q  <= wb_csr_wdata_i[CRMD_IE_BIT];
                        crmd_pie_q <= wb_csr_wdata_i[CRMD_PIE_BIT];
                    end
                    CSR_ECFG:   ecfg_lie_q <= int_pack(wb_word.fields.is_bits);
                    CSR_ESTAT:  estat_sw_q <= wb_word.fields.is_bits[1:0];  // SW bits only
                    CSR_ERA:    era_q      <= wb_csr_wdata_i;
                    CSR_BADV:   badv_q     <= wb_csr_wdata_i;
                    CSR_EENTRY: eentry_q   <= wb_csr_wdata_i & EENTRY_MASK;
                    default: ;
                endcase
            end
            // Later assignments win over a write-back to the same register
            if (bus.is_exception) begin
                era_q      <= bus.exc_pc;
                badv_q     <= bus.exc_badv;
                ecode_q    <= bus.ecode;
                esubcode_q <= bus.subecode;
                crmd_pie_q <= crmd_ie_q;
                crmd_ie_q  <= 1'b0;
            end else if (bus.is_ertn) begin
                crmd_ie_q  <= crmd_pie_q;
            end
        end
    end

    // **************************************************
    // Read port and state to ctrl
    // **************************************************

    always_comb begin : read_mux
        estat_rd.raw             = '0;
        estat_rd.fields.is_bits  = int_unpack(estat_is);
        estat_rd.fields.ecode    = ecode_q;
        estat_rd.fields.esubcode = esubcode_q;
        csr_rdata_o              = '0;
        case (csr_raddr_i)
            CSR_CRMD: begin
                csr_rdata_o[CRMD_IE_BIT]  = crmd_ie_q;
                csr_rdata_o[CRMD_PIE_BIT] = crmd_pie_q;
            end
            CSR_ECFG:   csr_rdata_o = 32'(int_unpack(ecfg_lie_q));
            CSR_ESTAT:  csr_rdata_o = estat_rd.raw;
            CSR_ERA:    csr_rdata_o = era_q;
            CSR_BADV:   csr_rdata_o = badv_q;
            CSR_EENTRY: csr_rdata_o = eentry_q;
            default:    csr_rdata_o = '0;
        endcase
    end

    assign bus.era_pc    = era_q;
    assign bus.eentry_va = eentry_q;
    assign bus.ecfg_lie  = ecfg_lie_q;
    assign bus.estat_is  = estat_is;
    assign bus.crmd_ie   = crmd_ie_q;

    // Memory stage never carries both
    excl_commit_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(bus.is_exception && bus.is_ertn));

    // A committed exception always names a cause
    exc_cause_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        bus.is_exception |-> bus.exc_cause != EXC_NOP);

    ie_reset_a: assert property (@(posedge clk_i) !rst_n_i |=> !crmd_ie_q);

endmodule

/* logic/ctrl.sv */
`timescale 1ns/1ns

module ctrl (
    input  logic [31:0]                                        mem_pc_i,
    input  logic [31:0]                                        mem_badv_i,
    input  logic [excp_pkg::EXC_SLOTS-1:0]                     mem_exc_valid_i,
    input  logic [excp_pkg::EXC_SLOTS*excp_pkg::CAUSE_W-1:0]   mem_exc_cause_i,
    input  logic                                               mem_is_ertn_i,
    input  logic                                               mem_is_idle_i,
    input  logic                                               continue_idle_i,
    input  logic [excp_pkg::PAUSE_REQS-1:0]                    pause_req_i,
    input  logic                                               wb_csr_we_i,
    input  logic [excp_pkg::CSR_ADDR_W-1:0]                    wb_csr_addr_i,
    input  logic [31:0]                                        wb_csr_wdata_i,
    ctrl_csr_if.ctrl                                           bus,
    output logic                                               exception_flush_o,
    output logic [31:0]                                        exception_new_pc_o,
    output logic                                               is_interrupt_o,
    output logic [excp_pkg::PAUSE_BITS-1:0]                    pause_o,
    output logic                                               send_inst1_en_o
);
    import excp_pkg::*;

    localparam logic [PAUSE_BITS-1:0] PAUSE_IF   = 7'b000_0001;
    localparam logic [PAUSE_BITS-1:0] PAUSE_ID   = 7'b000_1111;
    localparam logic [PAUSE_BITS-1:0] PAUSE_DISP = 7'b001_1111;
    localparam logic [PAUSE_BITS-1:0] PAUSE_EX   = 7'b011_1111;
    localparam logic [PAUSE_BITS-1:0] PAUSE_MEM  = 7'b111_1111;

    estat_word_u         wb_word;
    logic [31:0]         era_cur;
    logic [31:0]         eentry_cur;
    logic [INT_BITS-1:0] lie_cur;
    logic [INT_BITS-1:0] is_cur;
    logic                ie_cur;
    logic [INT_BITS-1:0] int_vec;
    logic                pause_idle;
    exc_cause_e          sel_cause;

    assign wb_word.raw = wb_csr_wdata_i;

    // **************************************************
    // Write-back forwarding
    // **************************************************

    always_comb begin : forward_csr
        era_cur    = bus.era_pc;
        eentry_cur = bus.eentry_va;
        lie_cur    = bus.ecfg_lie;
        is_cur     = bus.estat_is;
        ie_cur     = bus.crmd_ie;
        if (wb_csr_we_i) begin
            case (wb_csr_addr_i)
                CSR_CRMD:   ie_cur      = wb_csr_wdata_i[CRMD_IE_BIT];
                CSR_ECFG:   lie_cur     = int_pack(wb_word.fields.is_bits);
                CSR_ESTAT:  is_cur[1:0] = wb_word.fields.is_bits[1:0];  // HW bits stay
                CSR_ERA:    era_cur     = wb_csr_wdata_i;
                CSR_EENTRY: eentry_cur  = wb_csr_wdata_i;   // Raw written value
                default: ;
            endcase
        end
    end

    // **************************************************
    // Exception select and cause encoding
    // **************************************************

    always_comb begin : slot_select
        sel_cause = EXC_NOP;
        for (int i = 0; i < EXC_SLOTS; i++) begin
            if (mem_exc_valid_i[i]) begin
                sel_cause = exc_cause_e'(mem_exc_cause_i[i*CAUSE_W +: CAUSE_W]);  // Highest wins
            end
        end
    end

    always_comb begin : cause_map
        bus.ecode    = '0;
        bus.subecode = '0;
        case (sel_cause)
            EXC_PIL:  bus.ecode = 6'h01;
            EXC_PIS:  bus.ecode = 6'h02;
            EXC_PIF:  bus.ecode = 6'h03;
            EXC_PME:  bus.ecode = 6'h04;
            EXC_PPI:  bus.ecode = 6'h07;
            EXC_ADEF: bus.ecode = 6'h08;
            EXC_ADEM: begin
                bus.ecode    = 6'h08;
                bus.subecode = 9'h001;
            end
            EXC_ALE:  bus.ecode = 6'h09;
            EXC_SYS:  bus.ecode = 6'h0b;
            EXC_BRK:  bus.ecode = 6'h0c;
            EXC_INE:  bus.ecode = 6'h0d;
            EXC_IPE:  bus.ecode = 6'h0e;
            EXC_FPD:  bus.ecode = 6'h0f;
            EXC_FPE:  bus.ecode = 6'h12;
            EXC_TLBR: bus.ecode = 6'h3f;
            default:  bus.ecode = 6'h00;    // INT
        endcase
    end

    assign bus.is_exception = |mem_exc_valid_i;
    assign bus.is_ertn      = mem_is_ertn_i;
    assign bus.exc_cause    = sel_cause;
    assign bus.exc_pc       = mem_pc_i;
    assign bus.exc_badv     = mem_badv_i;

    assign exception_flush_o  = bus.is_exception || mem_is_ertn_i;
    assign exception_new_pc_o = mem_is_ertn_i ? era_cur : eentry_cur;

    // **************************************************
    // Interrupt gating and pause mask
    // **************************************************

    assign int_vec        = {INT_BITS{ie_cur}} & lie_cur & is_cur;
    assign is_interrupt_o = |int_vec;

    // Idle holds until an interrupt arrives or idle is released
    assign pause_idle = mem_is_idle_i && !is_interrupt_o && !continue_idle_i;

    always_comb begin : pause_ctrl
        if (pause_req_i[REQ_IF]) begin
            pause_o = PAUSE_IF;
        end else if (pause_req_i[REQ_ID]) begin
            pause_o = PAUSE_ID;
        end else if (pause_req_i[REQ_DISPATCH]) begin
            pause_o = PAUSE_DISP;
        end else if (pause_req_i[REQ_EX]) begin
            pause_o = PAUSE_EX;
        end else if (pause_req_i[REQ_MEM] || pause_idle) begin
            pause_o = PAUSE_MEM;
        end else begin
            pause_o = '0;
        end
    end

    assign send_inst1_en_o = ~pause_o[2];   // Instruction buffer stage

    // Stalled stages always form a run from the front end
    pause_contig_a: assert final (((pause_o + 1'b1) & pause_o) == '0)
        else $error("pause mask %b not contiguous", pause_o);

endmodule

/* logic/ctrl_csr_if.sv */
`timescale 1ns/1ns

interface ctrl_csr_if;
    import excp_pkg::*;

    // Current CSR state
    logic [31:0]           era_pc;
    logic [31:0]           eentry_va;
    logic [INT_BITS-1:0]   ecfg_lie;
    logic [INT_BITS-1:0]   estat_is;
    logic                  crmd_ie;

    // Commit request
    logic                  is_exception;
    logic                  is_ertn;
    exc_cause_e            exc_cause;
    logic [31:0]           exc_pc;
    logic [31:0]           exc_badv;
    logic [ECODE_W-1:0]    ecode;
    logic [ESUBCODE_W-1:0] subecode;

    modport csr (
        output era_pc, eentry_va, ecfg_lie, estat_is, crmd_ie,
        input  is_exception, is_ertn, exc_cause, exc_pc, exc_badv, ecode, subecode
    );

    modport ctrl (
        input  era_pc, eentry_va, ecfg_lie, estat_is, crmd_ie,
        output is_exception, is_ertn, exc_cause, exc_pc, exc_badv, ecode, subecode
    );

endinterface

/* logic/excp_pkg.sv */
package excp_pkg;

    // **************************************************
    // CSR addresses
    // **************************************************

    localparam int CSR_ADDR_W = 14;

    localparam logic [CSR_ADDR_W-1:0] CSR_CRMD   = 14'h000;
    localparam logic [CSR_ADDR_W-1:0] CSR_ECFG   = 14'h004;
    localparam logic [CSR_ADDR_W-1:0] CSR_ESTAT  = 14'h005;
    localparam logic [CSR_ADDR_W-1:0] CSR_ERA    = 14'h006;
    localparam logic [CSR_ADDR_W-1:0] CSR_BADV   = 14'h007;
    localparam logic [CSR_ADDR_W-1:0] CSR_EENTRY = 14'h00c;

    localparam int CRMD_IE_BIT  = 2;
    localparam int CRMD_PIE_BIT = 3;    // Saved IE, restored by ertn

    // **************************************************
    // Widths
    // **************************************************

    localparam int EXC_SLOTS   = 6;
    localparam int CAUSE_W     = 5;
    localparam int ECODE_W     = 6;
    localparam int ESUBCODE_W  = 9;
    localparam int INT_BITS    = 12;    // ESTAT/ECFG bits 12:11 and 9:0
    localparam int HW_INT_BITS = 8;
    localparam int PAUSE_BITS  = 7;
    localparam int PAUSE_REQS  = 5;

    // Pause request bit positions
    localparam int REQ_IF       = 0;
    localparam int REQ_ID       = 1;
    localparam int REQ_DISPATCH = 2;
    localparam int REQ_EX       = 3;
    localparam int REQ_MEM      = 4;

    typedef enum logic [CAUSE_W-1:0] {
        EXC_NOP,
        EXC_INT,
        EXC_PIL,
        EXC_PIS,
        EXC_PIF,
        EXC_PME,
        EXC_PPI,
        EXC_ADEF,
        EXC_ADEM,
        EXC_ALE,
        EXC_SYS,
        EXC_BRK,
        EXC_INE,
        EXC_IPE,
        EXC_FPD,
        EXC_FPE,
        EXC_TLBR
    } exc_cause_e;

    // ESTAT word, raw or by field
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic                  rsv_hi;
            logic [ESUBCODE_W-1:0] esubcode;    // 30:22
            logic [ECODE_W-1:0]    ecode;       // 21:16
            logic [2:0]            rsv_lo;
            logic [12:0]           is_bits;     // 12:0, bit 10 unused
        } fields;
    } estat_word_u;

    // Squeeze out the hole at bit 10
    function automatic logic [INT_BITS-1:0] int_pack(input logic [12:0] word);
        return {word[12:11], word[9:0]};
    endfunction

    function automatic logic [12:0] int_unpack(input logic [INT_BITS-1:0] bits);
        return {bits[11:10], 1'b0, bits[9:0]};
    endfunction

endpackage

/* logic/excp_unit.sv */
`timescale 1ns/1ns

module excp_unit #(
    parameter int ENTRY_ALIGN = 6
) (
    input  logic                                               clk_i,
    input  logic                                               rst_n_i,
    input  logic [31:0]                                        mem_pc_i,
    input  logic [31:0]                                        mem_badv_i,
    input  logic [excp_pkg::EXC_SLOTS-1:0]                     mem_exc_valid_i,
    input  logic [excp_pkg::EXC_SLOTS*excp_pkg::CAUSE_W-1:0]   mem_exc_cause_i,
    input  logic                                               mem_is_ertn_i,
    input  logic                                               mem_is_idle_i,
    input  logic                                               continue_idle_i,
    input  logic [excp_pkg::PAUSE_REQS-1:0]                    pause_req_i,  // mem ex disp id if
    input  logic [excp_pkg::HW_INT_BITS-1:0]                   hw_int_i,
    input  logic                                               wb_csr_we_i,
    input  logic [excp_pkg::CSR_ADDR_W-1:0]                    wb_csr_addr_i,
    input  logic [31:0]                                        wb_csr_wdata_i,
    input  logic [excp_pkg::CSR_ADDR_W-1:0]                    csr_raddr_i,
    output logic [31:0]                                        csr_rdata_o,
    output logic                                               exception_flush_o,
    output logic [31:0]                                        exception_new_pc_o,
    output logic                                               is_interrupt_o,
    output logic [excp_pkg::PAUSE_BITS-1:0]                    pause_o,
    output logic                                               send_inst1_en_o
);

    ctrl_csr_if csr_bus ();

    csr_file #(
        .ENTRY_ALIGN (ENTRY_ALIGN)
    ) u_csr_file (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .hw_int_i       (hw_int_i),
        .wb_csr_we_i    (wb_csr_we_i),
        .wb_csr_addr_i  (wb_csr_addr_i),
        .wb_csr_wdata_i (wb_csr_wdata_i),
        .csr_raddr_i    (csr_raddr_i),
        .csr_rdata_o    (csr_rdata_o),
        .bus            (csr_bus.csr)
    );

    // Same write-back port also forwarded into ctrl
    ctrl u_ctrl (
        .mem_pc_i           (mem_pc_i),
        .mem_badv_i         (mem_badv_i),
        .mem_exc_valid_i    (mem_exc_valid_i),
        .mem_exc_cause_i    (mem_exc_cause_i),
        .mem_is_ertn_i      (mem_is_ertn_i),
        .mem_is_idle_i      (mem_is_idle_i),
        .continue_idle_i    (continue_idle_i),
        .pause_req_i        (pause_req_i),
        .wb_csr_we_i        (wb_csr_we_i),
        .wb_csr_addr_i      (wb_csr_addr_i),
        .wb_csr_wdata_i     (wb_csr_wdata_i),
        .bus                (csr_bus.ctrl),
        .exception_flush_o  (exception_flush_o),
        .exception_new_pc_o (exception_new_pc_o),
        .is_interrupt_o     (is_interrupt_o),
        .pause_o            (pause_o),
        .send_inst1_en_o    (send_inst1_en_o)
    );

endmodule
